//--- design/usb_bulk_endpoint.sv
`timescale 1ns/1ps

module usb_bulk_endpoint
  import usb_xact_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     start_i,
  input  logic     start_in_i,
  input  logic     in_ready_i,
  input  logic     out_ready_i,
  input  usb_hsk_t hsk_rx_i,
  input  logic     hsk_sent_i,
  input  logic     usb_sent_i,
  input  logic     rx_beat_i,
  input  logic     rx_last_i,
  output logic     busy_o,
  output logic     done_o,
  output ep_resp_t resp_o
);

  ep_state_e state_q;
  ep_state_e state_d;

  // DATA0/DATA1 toggle of this endpoint
  logic toggle_q;
  logic flip;

  // Handshake chosen when the OUT transfer started
  logic out_ack_q;

  logic done_q;
  logic finish;

  always_comb begin
    state_d = state_q;
    flip    = 1'b0;
    finish  = 1'b0;
    case (state_q)
      EP_IDLE: begin
        if (start_i) begin
          if (start_in_i) begin
            // Nothing to send gives a zero-length packet
            state_d = in_ready_i ? EP_IN_DATA : EP_IN_ZERO;
          end else begin
            state_d = out_ready_i ? EP_OUT_FWD : EP_OUT_DROP;
          end
        end
      end
      EP_IN_DATA, EP_IN_ZERO: begin
        if (usb_sent_i) begin
          state_d = EP_IN_WAIT;
        end
      end
      EP_IN_WAIT: begin
        // Host answer closes the IN and only ACK moves the toggle
        if (hsk_rx_i.send) begin
          state_d = EP_IDLE;
          flip    = (hsk_rx_i.htype == HSK_ACK);
          finish  = 1'b1;
        end
      end
      EP_OUT_FWD, EP_OUT_DROP: begin
        if (rx_beat_i && rx_last_i) begin
          state_d = EP_OUT_HSK;
        end
      end
      EP_OUT_HSK: begin
        if (hsk_sent_i) begin
          state_d = EP_IDLE;
          flip    = out_ack_q;
          finish  = 1'b1;
        end
      end
      default: begin
        state_d = EP_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q  <= EP_IDLE;
      toggle_q <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= finish;
      if (flip) begin
        toggle_q <= ~toggle_q;
      end
    end
  end

  // ACK when the application takes the bytes, NAK when they are dropped
  always_ff @(posedge clock) begin
    if (start_i && !start_in_i) begin
      out_ack_q <= out_ready_i;
    end
  end

  assign busy_o = (state_q != EP_IDLE);
  assign done_o = done_q;

  // Requests decode the state and stay up until the matching sent strobe
  assign resp_o.dat.send  = (state_q == EP_IN_DATA) || (state_q == EP_IN_ZERO);
  assign resp_o.dat.pid   = toggle_q ? DATA1 : DATA0;
  assign resp_o.dat.zero  = (state_q == EP_IN_ZERO);
  assign resp_o.hsk.send  = (state_q == EP_OUT_HSK);
  assign resp_o.hsk.htype = out_ack_q ? HSK_ACK : HSK_NAK;
  assign resp_o.fwd       = (state_q == EP_OUT_FWD);

  // Never a handshake and a data packet requested together
  a_one_request : assert property (
    @(posedge clock) disable iff (reset)
    !(resp_o.hsk.send && resp_o.dat.send)
  );

endmodule

//--- design/usb_response_arbiter.sv
`timescale 1ns/1ps

module usb_response_arbiter
  import usb_xact_pkg::*;
(
  input  logic                           clock,
  input  logic                           reset,
  input  ep_vec_t                        ep_busy_i,
  input  ep_vec_t                        ep_done_i,
  input  ep_resp_t     [NUM_BULK_EP-1:0] ep_resp_i,
  input  byte_stream_t [NUM_BULK_EP-1:0] blk_in_i,
  input  logic                           usb_tx_tready_i,
  input  byte_stream_t                   usb_rx_i,
  input  ep_vec_t                        blk_out_tready_i,
  output ep_vec_t                        busy_o,
  output usb_hsk_t                       hsk_tx_o,
  output data_req_t                      usb_send_o,
  output byte_stream_t                   usb_tx_o,
  output ep_vec_t                        blk_in_tready_o,
  output logic                           usb_rx_tready_o,
  output byte_stream_t [NUM_BULK_EP-1:0] blk_out_o,
  output logic                           rx_beat_o,
  output logic                           rx_last_o
);

  ep_vec_t in_sel;
  ep_vec_t fwd_sel;

  always_comb begin
    hsk_tx_o = '0;
    usb_send_o = '0;
    usb_tx_o = '0;
    in_sel = '0;
    fwd_sel = '0;
    // At most one engine is busy, so an OR of masked requests selects it
    for (int i = 0; i < NUM_BULK_EP; i++) begin
      if (ep_busy_i[i]) begin
        hsk_tx_o   = hsk_tx_o | ep_resp_i[i].hsk;
        usb_send_o = usb_send_o | ep_resp_i[i].dat;
        // IN stream is live only for a packet with payload
        in_sel[i]  = ep_resp_i[i].dat.send && !ep_resp_i[i].dat.zero;
        fwd_sel[i] = ep_resp_i[i].fwd;
      end
      if (in_sel[i]) begin
        usb_tx_o = usb_tx_o | blk_in_i[i];
      end
    end
  end

  // Encoder back-pressure reaches the application without a register
  assign blk_in_tready_o = in_sel & {NUM_BULK_EP{usb_tx_tready_i}};

  always_comb begin
    for (int i = 0; i < NUM_BULK_EP; i++) begin
      blk_out_o[i].tvalid = fwd_sel[i] && usb_rx_i.tvalid;
      blk_out_o[i].tlast  = usb_rx_i.tlast;
      blk_out_o[i].tdata  = usb_rx_i.tdata;
    end
  end

  // Outside a forwarding OUT the bytes drain and are lost
  assign usb_rx_tready_o = (fwd_sel != '0) ? ((fwd_sel & blk_out_tready_i) != '0) : 1'b1;

  assign rx_beat_o = usb_rx_i.tvalid && usb_rx_tready_o;
  assign rx_last_o = usb_rx_i.tlast;

  assign busy_o = ep_busy_i;

  // Engines never overlap
  a_busy_onehot : assert property (
    @(posedge clock) disable iff (reset)
    $onehot0(ep_busy_i)
  );

  // Done pulses in the cycle where that engine drops busy
  a_done_on_fall : assert property (
    @(posedge clock) disable iff (reset)
    ep_done_i == ($past(ep_busy_i) & ~ep_busy_i)
  );

endmodule

//--- design/usb_token_dispatch.sv
`timescale 1ns/1ps

module usb_token_dispatch
  import usb_xact_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  usb_addr_t  usb_addr_i,
  input  usb_token_t tok_i,
  input  ep_vec_t    ep_busy_i,
  output ep_vec_t    ep_start_o,
  output logic       start_in_o,
  output logic       xact_err_o
);

  ep_vec_t   start_q;
  logic      start_in_q;
  logic      err_q;

  logic      tok_hit;
  logic      tok_data;
  logic      endp_ok;
  usb_endp_t ep_idx;

  // A token counts only for our address and with every engine idle
  // A start still in flight also blocks, the engine is not busy yet
  assign tok_hit = tok_i.recv && (tok_i.addr == usb_addr_i) &&
                   (ep_busy_i == '0) && (start_q == '0);

  assign tok_data = (tok_i.ttype == TOK_IN) || (tok_i.ttype == TOK_OUT);

  // Bulk endpoints are numbered from 1
  assign endp_ok = (tok_i.endp != '0) &&
                   (tok_i.endp <= usb_endp_t'(NUM_BULK_EP));

  // Engine index of the addressed endpoint
  assign ep_idx = tok_i.endp - usb_endp_t'(1);

  always_ff @(posedge clock) begin
    if (reset) begin
      start_q <= '0;
      err_q   <= 1'b0;
    end else begin
      // Start and error are single-cycle pulses
      start_q <= '0;
      err_q   <= 1'b0;
      if (tok_hit && tok_data && endp_ok) begin
        start_q <= ep_vec_t'(1) << ep_idx;
      end
      // SETUP has no engine here, same for a bad endpoint number
      if (tok_hit && ((tok_i.ttype == TOK_SETUP) || (tok_data && !endp_ok))) begin
        err_q <= 1'b1;
      end
    end
  end

  // Direction only matters alongside a start pulse
  always_ff @(posedge clock) begin
    if (tok_hit) begin
      start_in_q <= (tok_i.ttype == TOK_IN);
    end
  end

  assign ep_start_o = start_q;
  assign start_in_o = start_in_q;
  assign xact_err_o = err_q;

  // At most one engine started, and exactly that one turns busy next
  a_start_onehot : assert property (
    @(posedge clock) disable iff (reset)
    $onehot0(ep_start_o)
  );

  a_start_busy : assert property (
    @(posedge clock) disable iff (reset)
    (ep_start_o != '0) |=> (ep_busy_i == $past(ep_start_o))
  );

endmodule

//--- design/usb_transactor.sv
`timescale 1ns/1ps

module usb_transactor
  import usb_xact_pkg::*;
(
  input  logic                           clock,
  input  logic                           reset,
  input  usb_addr_t                      usb_addr_i,
  // Decoder side
  input  usb_token_t                     tok_i,
  input  usb_hsk_t                       hsk_rx_i,
  input  byte_stream_t                   usb_rx_i,
  output logic                           usb_rx_tready_o,
  // Encoder side
  output usb_hsk_t                       hsk_tx_o,
  input  logic                           hsk_sent_i,
  output data_req_t                      usb_send_o,
  input  logic                           usb_sent_i,
  output byte_stream_t                   usb_tx_o,
  input  logic                           usb_tx_tready_i,
  // Application streams, one per bulk endpoint
  input  byte_stream_t [NUM_BULK_EP-1:0] blk_in_i,
  input  ep_vec_t                        blk_in_ready_i,
  input  ep_vec_t                        blk_out_ready_i,
  output ep_vec_t                        blk_in_tready_o,
  output byte_stream_t [NUM_BULK_EP-1:0] blk_out_o,
  input  ep_vec_t                        blk_out_tready_i,
  output logic                           xact_err_o
);

  ep_vec_t                    ep_start;
  logic                       start_in;
  ep_vec_t                    ep_done;
  ep_vec_t                    ep_busy;
  ep_vec_t                    busy_to_disp;
  ep_resp_t [NUM_BULK_EP-1:0] ep_resp;
  logic                       rx_beat;
  logic                       rx_last;

  usb_token_dispatch u_usb_token_dispatch (
    .clock      (clock),
    .reset      (reset),
    .usb_addr_i (usb_addr_i),
    .tok_i      (tok_i),
    .ep_busy_i  (busy_to_disp),
    .ep_start_o (ep_start),
    .start_in_o (start_in),
    .xact_err_o (xact_err_o)
  );

  // One engine per bulk endpoint, all sharing the broadcast strobes
  for (genvar i = 0; i < NUM_BULK_EP; i++) begin : g_ep
    usb_bulk_endpoint u_usb_bulk_endpoint (
      .clock       (clock),
      .reset       (reset),
      .start_i     (ep_start[i]),
      .start_in_i  (start_in),
      .in_ready_i  (blk_in_ready_i[i]),
      .out_ready_i (blk_out_ready_i[i]),
      .hsk_rx_i    (hsk_rx_i),
      .hsk_sent_i  (hsk_sent_i),
      .usb_sent_i  (usb_sent_i),
      .rx_beat_i   (rx_beat),
      .rx_last_i   (rx_last),
      .busy_o      (ep_busy[i]),
      .done_o      (ep_done[i]),
      .resp_o      (ep_resp[i])
    );
  end

  usb_response_arbiter u_usb_response_arbiter (
    .clock            (clock),
    .reset            (reset),
    .ep_busy_i        (ep_busy),
    .ep_done_i        (ep_done),
    .ep_resp_i        (ep_resp),
    .blk_in_i         (blk_in_i),
    .usb_tx_tready_i  (usb_tx_tready_i),
    .usb_rx_i         (usb_rx_i),
    .blk_out_tready_i (blk_out_tready_i),
    .busy_o           (busy_to_disp),
    .hsk_tx_o         (hsk_tx_o),
    .usb_send_o       (usb_send_o),
    .usb_tx_o         (usb_tx_o),
    .blk_in_tready_o  (blk_in_tready_o),
    .usb_rx_tready_o  (usb_rx_tready_o),
    .blk_out_o        (blk_out_o),
    .rx_beat_o        (rx_beat),
    .rx_last_o        (rx_last)
  );

endmodule

//--- design/usb_xact_pkg.sv
package usb_xact_pkg;

  // Bulk endpoints served, engine i answers endpoint i+1
  localparam int NUM_BULK_EP = 2;

  // Widths with a meaning on the bus
  typedef logic [6:0] usb_addr_t;
  typedef logic [3:0] usb_endp_t;
  typedef logic [7:0] usb_byte_t;

  // One bit per bulk engine
  typedef logic [NUM_BULK_EP-1:0] ep_vec_t;

  // Token PID codes as seen from the decoder
  typedef enum logic [1:0] {
    TOK_OUT   = 2'b00,
    TOK_SOF   = 2'b01,
    TOK_IN    = 2'b10,
    TOK_SETUP = 2'b11
  } tok_type_e;

  typedef enum logic [1:0] {
    HSK_ACK = 2'b00,
    HSK_NAK = 2'b10
  } hsk_type_e;

  typedef enum logic [1:0] {
    DATA0 = 2'b00,
    DATA1 = 2'b10
  } data_pid_e;

  // Per-endpoint engine states
  typedef enum logic [2:0] {
    EP_IDLE,
    EP_IN_DATA,
    EP_IN_ZERO,
    EP_IN_WAIT,
    EP_OUT_FWD,
    EP_OUT_DROP,
    EP_OUT_HSK
  } ep_state_e;

  // Decoded token, recv is a single-cycle strobe
  typedef struct packed {
    logic      recv;
    tok_type_e ttype;
    usb_addr_t addr;
    usb_endp_t endp;
  } usb_token_t;

  // Handshake, same shape in both directions
  typedef struct packed {
    logic      send;
    hsk_type_e htype;
  } usb_hsk_t;

  typedef struct packed {
    logic      tvalid;
    logic      tlast;
    usb_byte_t tdata;
  } byte_stream_t;

  // Data packet request toward the encoder
  typedef struct packed {
    logic      send;
    data_pid_e pid;
    logic      zero;
  } data_req_t;

  // What one engine asks of the shared encoder and receive path
  typedef struct packed {
    usb_hsk_t  hsk;
    data_req_t dat;
    logic      fwd;
  } ep_resp_t;

endpackage

//--- dv/usb_tb_vectors.svh
`ifndef USB_TB_VECTORS_SVH
`define USB_TB_VECTORS_SVH

// Columns are name, token, address, endpoint, in_ready, out_ready, byte count,
// host handshake, then expected response, PID, zero flag, handshake, error flag
typedef struct {
  string     name;
  tok_type_e ttype;
  usb_addr_t addr;
  usb_endp_t endp;
  logic      in_rdy;
  logic      out_rdy;
  int        nbytes;
  hsk_type_e host_hsk;
  logic      resp;
  data_pid_e pid;
  logic      zero;
  hsk_type_e hsk;
  logic      err;
} tb_row_t;

localparam int NUM_ROWS = 18;

tb_row_t test_rows [NUM_ROWS];

// Toggles of both endpoints start at DATA0 after reset
task automatic load_table();
  test_rows[0]  = '{"in_ep1_first", TOK_IN, DEV_ADDR, 4'd1, 1'b1, 1'b0, 4,
                    HSK_ACK, 1'b1, DATA0, 1'b0, HSK_ACK, 1'b0};
  test_rows[1]  = '{"in_ep1_second", TOK_IN, DEV_ADDR, 4'd1, 1'b1, 1'b0, 3,
                    HSK_ACK, 1'b1, DATA1, 1'b0, HSK_ACK, 1'b0};
  // Empty packet, host NAK keeps the toggle
  test_rows[2]  = '{"in_ep1_zlp_nak", TOK_IN, DEV_ADDR, 4'd1, 1'b0, 1'b0, 0,
                    HSK_NAK, 1'b1, DATA0, 1'b1, HSK_ACK, 1'b0};
  test_rows[3]  = '{"in_ep1_zlp_ack", TOK_IN, DEV_ADDR, 4'd1, 1'b0, 1'b0, 0,
                    HSK_ACK, 1'b1, DATA0, 1'b1, HSK_ACK, 1'b0};
  test_rows[4]  = '{"out_ep1_ack", TOK_OUT, DEV_ADDR, 4'd1, 1'b0, 1'b1, 5,
                    HSK_ACK, 1'b1, DATA0, 1'b0, HSK_ACK, 1'b0};
  test_rows[5]  = '{"in_ep1_after_out", TOK_IN, DEV_ADDR, 4'd1, 1'b1, 1'b0, 2,
                    HSK_ACK, 1'b1, DATA0, 1'b0, HSK_ACK, 1'b0};
  test_rows[6]  = '{"out_ep1_nak", TOK_OUT, DEV_ADDR, 4'd1, 1'b0, 1'b0, 3,
                    HSK_ACK, 1'b1, DATA0, 1'b0, HSK_NAK, 1'b0};
  test_rows[7]  = '{"in_ep1_after_nak", TOK_IN, DEV_ADDR, 4'd1, 1'b1, 1'b0, 1,
                    HSK_NAK, 1'b1, DATA1, 1'b0, HSK_ACK, 1'b0};
  // Endpoint 2 runs its own toggle
  test_rows[8]  = '{"in_ep2_first", TOK_IN, DEV_ADDR, 4'd2, 1'b1, 1'b0, 4,
                    HSK_ACK, 1'b1, DATA0, 1'b0, HSK_ACK, 1'b0};
  test_rows[9]  = '{"out_ep2_ack", TOK_OUT, DEV_ADDR, 4'd2, 1'b0, 1'b1, 2,
                    HSK_ACK, 1'b1, DATA0, 1'b0, HSK_ACK, 1'b0};
  test_rows[10] = '{"in_ep1_keep", TOK_IN, DEV_ADDR, 4'd1, 1'b1, 1'b0, 2,
                    HSK_ACK, 1'b1, DATA1, 1'b0, HSK_ACK, 1'b0};
  test_rows[11] = '{"in_ep2_zlp", TOK_IN, DEV_ADDR, 4'd2, 1'b0, 1'b0, 0,
                    HSK_ACK, 1'b1, DATA0, 1'b1, HSK_ACK, 1'b0};
  // Ignored and rejected tokens
  test_rows[12] = '{"in_other_addr", TOK_IN, 7'h11, 4'd1, 1'b1, 1'b0, 0,
                    HSK_ACK, 1'b0, DATA0, 1'b0, HSK_ACK, 1'b0};
  test_rows[13] = '{"sof_token", TOK_SOF, DEV_ADDR, 4'd0, 1'b1, 1'b0, 0,
                    HSK_ACK, 1'b0, DATA0, 1'b0, HSK_ACK, 1'b0};
  test_rows[14] = '{"setup_ep0", TOK_SETUP, DEV_ADDR, 4'd0, 1'b1, 1'b0, 0,
                    HSK_ACK, 1'b0, DATA0, 1'b0, HSK_ACK, 1'b1};
  test_rows[15] = '{"in_ep0", TOK_IN, DEV_ADDR, 4'd0, 1'b1, 1'b0, 0,
                    HSK_ACK, 1'b0, DATA0, 1'b0, HSK_ACK, 1'b1};
  test_rows[16] = '{"in_ep3", TOK_IN, DEV_ADDR, 4'd3, 1'b1, 1'b0, 0,
                    HSK_ACK, 1'b0, DATA0, 1'b0, HSK_ACK, 1'b1};
  test_rows[17] = '{"in_ep1_after_err", TOK_IN, DEV_ADDR, 4'd1, 1'b1, 1'b0, 3,
                    HSK_ACK, 1'b1, DATA0, 1'b0, HSK_ACK, 1'b0};
endtask

`endif

//--- dv/usb_transactor_tb.sv
`timescale 1ns/1ps

module usb_transactor_tb
  import usb_xact_pkg::*;
();

  localparam int        CLK_PERIOD   = 100;
  localparam int        ROW_CYCLES   = 300;
  localparam int        ROW_LIMIT    = 200;
  localparam int        QUIET_CYCLES = 8;
  localparam usb_addr_t DEV_ADDR     = 7'h2A;

  `include "usb_tb_vectors.svh"

  logic                           clock;
  logic                           reset;
  usb_addr_t                      usb_addr_i;
  usb_token_t                     tok_i;
  usb_hsk_t                       hsk_rx_i;
  byte_stream_t                   usb_rx_i;
  logic                           usb_rx_tready_o;
  usb_hsk_t                       hsk_tx_o;
  logic                           hsk_sent_i;
  data_req_t                      usb_send_o;
  logic                           usb_sent_i;
  byte_stream_t                   usb_tx_o;
  logic                           usb_tx_tready_i;
  byte_stream_t [NUM_BULK_EP-1:0] blk_in_i;
  ep_vec_t                        blk_in_ready_i;
  ep_vec_t                        blk_out_ready_i;
  ep_vec_t                        blk_in_tready_o;
  byte_stream_t [NUM_BULK_EP-1:0] blk_out_o;
  ep_vec_t                        blk_out_tready_i;
  logic                           xact_err_o;

  integer seed = 32'h9631;
  int     fail_count = 0;
  int     row_fails = 0;
  int     rows_passed = 0;

  usb_transactor u_usb_transactor (
    .clock            (clock),
    .reset            (reset),
    .usb_addr_i       (usb_addr_i),
    .tok_i            (tok_i),
    .hsk_rx_i         (hsk_rx_i),
    .usb_rx_i         (usb_rx_i),
    .usb_rx_tready_o  (usb_rx_tready_o),
    .hsk_tx_o         (hsk_tx_o),
    .hsk_sent_i       (hsk_sent_i),
    .usb_send_o       (usb_send_o),
    .usb_sent_i       (usb_sent_i),
    .usb_tx_o         (usb_tx_o),
    .usb_tx_tready_i  (usb_tx_tready_i),
    .blk_in_i         (blk_in_i),
    .blk_in_ready_i   (blk_in_ready_i),
    .blk_out_ready_i  (blk_out_ready_i),
    .blk_in_tready_o  (blk_in_tready_o),
    .blk_out_o        (blk_out_o),
    .blk_out_tready_i (blk_out_tready_i),
    .xact_err_o       (xact_err_o)
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // Every row gets ROW_CYCLES and reset gets a few more
  initial begin
    #((NUM_ROWS * ROW_CYCLES + 10) * CLK_PERIOD);
    $display("Watchdog expired, the run did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

  task automatic report_mismatch(input string test, input string what, input int exp,
                                 input int act);
    $display("Mismatch %s %s expected %0h actual %0h", test, what, exp, act);
    row_fails++;
    fail_count++;
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    row_fails++;
    fail_count++;
  endtask

  // Stray bytes offered to an idle DUT right after reset must not pass
  task automatic check_reset_state();
    usb_rx_i <= {1'b1, 1'b1, 8'h5A};
    for (int j = 0; j < NUM_BULK_EP; j++) begin
      blk_in_i[j] <= {1'b1, 1'b1, 8'hA5};
    end
    @(posedge clock);
    if (hsk_tx_o.send || usb_send_o.send || xact_err_o) begin
      report_failure("A request or error output is active after reset");
    end
    if (usb_tx_o.tvalid || (blk_out_o[0].tvalid || blk_out_o[NUM_BULK_EP-1].tvalid)) begin
      report_failure("A stream output is valid after reset");
    end
    if (!usb_rx_tready_o) begin
      report_failure("usb_rx_tready_o is low while no OUT transfer runs");
    end
    usb_rx_i <= '0;
    blk_in_i <= '0;
  endtask

  task automatic run_row(input int r);
    tb_row_t   row;
    usb_byte_t payload[$];
    usb_byte_t in_q[$];
    usb_byte_t rx_q[$];
    usb_byte_t exp_q[$];
    int        ep_num;
    int        idx;
    int        cyc = 0;
    int        ntx = 0;
    int        err_cnt = 0;
    int        err_cyc = 0;
    int        send_cyc = 0;
    int        sent_at = 0;
    int        last_cyc = 0;
    int        hsk_cyc = 0;
    int        done_at = 0;
    bit        is_in;
    bit        finished = 1'b0;

    row       = test_rows[r];
    row_fails = 0;
    ep_num    = int'(row.endp);
    idx       = (ep_num >= 1 && ep_num <= NUM_BULK_EP) ? ep_num - 1 : 0;
    is_in     = (row.ttype == TOK_IN);
    for (int k = 0; k < row.nbytes; k++) begin
      payload.push_back(usb_byte_t'($random(seed)));
    end
    // Bytes are only expected at the far side when the application takes part
    if (is_in && row.in_rdy) begin
      in_q  = payload;
      exp_q = payload;
    end
    if (row.ttype == TOK_OUT) begin
      rx_q = payload;
      if (row.out_rdy) begin
        exp_q = payload;
      end
    end

    @(posedge clock);
    tok_i           <= {1'b1, row.ttype, row.addr, row.endp};
    blk_in_ready_i  <= {NUM_BULK_EP{row.in_rdy}};
    blk_out_ready_i <= {NUM_BULK_EP{row.out_rdy}};
    if (in_q.size() > 0) begin
      blk_in_i[idx] <= {1'b1, in_q.size() == 1, in_q[0]};
    end

    while (!finished && cyc < ROW_LIMIT) begin
      @(posedge clock);
      cyc++;
      // Strobes fall back unless set again below
      tok_i.recv    <= 1'b0;
      hsk_rx_i.send <= 1'b0;
      usb_sent_i    <= 1'b0;
      hsk_sent_i    <= 1'b0;

      if (xact_err_o) begin
        err_cnt++;
        err_cyc = cyc;
      end

      // Application IN source
      if (blk_in_i[idx].tvalid && blk_in_tready_o[idx]) begin
        void'(in_q.pop_front());
      end
      if (in_q.size() > 0) begin
        blk_in_i[idx] <= {1'b1, in_q.size() == 1, in_q[0]};
      end else begin
        blk_in_i[idx] <= '0;
      end

      // Encoder sees the data request
      if (usb_send_o.send && send_cyc == 0) begin
        send_cyc = cyc;
        if (!is_in) begin
          report_failure($sformatf("%s requested a data packet for an OUT", row.name));
        end
        if (usb_send_o.pid != row.pid) begin
          report_mismatch(row.name, "pid", int'(row.pid), int'(usb_send_o.pid));
        end
        if (usb_send_o.zero != row.zero) begin
          report_mismatch(row.name, "zero", int'(row.zero), int'(usb_send_o.zero));
        end
        // Empty packet goes out without a byte
        if (usb_send_o.zero) begin
          usb_sent_i <= 1'b1;
          sent_at = cyc;
        end
      end
      // Encoder takes payload bytes
      if (usb_tx_o.tvalid && usb_tx_tready_i) begin
        ntx++;
        if (exp_q.size() == 0) begin
          report_failure($sformatf("%s sent a byte on usb_tx_o that was not expected",
                                   row.name));
        end else begin
          if (usb_tx_o.tdata != exp_q[0]) begin
            report_mismatch(row.name, "tx byte", int'(exp_q[0]), int'(usb_tx_o.tdata));
          end
          void'(exp_q.pop_front());
        end
        if (usb_tx_o.tlast != (ntx == row.nbytes)) begin
          report_mismatch(row.name, "tx tlast", int'(ntx == row.nbytes),
                          int'(usb_tx_o.tlast));
        end
        if (usb_tx_o.tlast) begin
          usb_sent_i <= 1'b1;
          sent_at = cyc;
        end
      end
      usb_tx_tready_i <= (($random(seed) & 3) != 0);

      // Host answers the packet two cycles after it went out
      if (sent_at > 0 && cyc == sent_at + 2) begin
        hsk_rx_i <= {1'b1, row.host_hsk};
        done_at = cyc + 2;
      end

      // Host OUT data is offered once the engine can be running
      if (cyc >= 2) begin
        if (usb_rx_i.tvalid && usb_rx_tready_o) begin
          if (usb_rx_i.tlast) begin
            last_cyc = cyc;
          end
          void'(rx_q.pop_front());
        end
        if (rx_q.size() > 0) begin
          usb_rx_i <= {1'b1, rx_q.size() == 1, rx_q[0]};
        end else begin
          usb_rx_i <= '0;
        end
      end

      // Application OUT sinks with random stalls
      for (int j = 0; j < NUM_BULK_EP; j++) begin
        if (blk_out_o[j].tvalid && blk_out_tready_i[j]) begin
          if (is_in || j != idx || exp_q.size() == 0) begin
            report_failure($sformatf("%s delivered an unexpected byte on blk_out_o[%0d]",
                                     row.name, j));
          end else begin
            if (blk_out_o[j].tdata != exp_q[0]) begin
              report_mismatch(row.name, "out byte", int'(exp_q[0]),
                              int'(blk_out_o[j].tdata));
            end
            if (blk_out_o[j].tlast != (exp_q.size() == 1)) begin
              report_mismatch(row.name, "out tlast", int'(exp_q.size() == 1),
                              int'(blk_out_o[j].tlast));
            end
            void'(exp_q.pop_front());
          end
        end
      end
      blk_out_tready_i <= ep_vec_t'($random(seed));

      // Handshake toward the host is due the cycle after the last byte
      if (hsk_tx_o.send && hsk_cyc == 0) begin
        hsk_cyc = cyc;
        if (is_in) begin
          report_failure($sformatf("%s sent a handshake during an IN", row.name));
        end
        if (hsk_tx_o.htype != row.hsk) begin
          report_mismatch(row.name, "handshake", int'(row.hsk), int'(hsk_tx_o.htype));
        end
        if (cyc != last_cyc + 1) begin
          report_mismatch(row.name, "handshake cycle", last_cyc + 1, cyc);
        end
      end
      if (hsk_cyc > 0 && cyc == hsk_cyc + 2) begin
        hsk_sent_i <= 1'b1;
        done_at = cyc + 2;
      end

      // Engine idle again, or the quiet window of an ignored token is over
      if (done_at > 0 && cyc == done_at) begin
        finished = 1'b1;
      end
      if (!row.resp && cyc == QUIET_CYCLES) begin
        finished = 1'b1;
      end
    end

    if (!finished) begin
      report_failure($sformatf("%s did not complete within %0d cycles", row.name, ROW_LIMIT));
    end
    if (err_cnt != (row.err ? 1 : 0)) begin
      report_mismatch(row.name, "error pulses", row.err ? 1 : 0, err_cnt);
    end
    // Error pulse one cycle after the token
    if (row.err && err_cnt == 1 && err_cyc != 2) begin
      report_mismatch(row.name, "error cycle", 2, err_cyc);
    end
    // Data request two cycles after the token
    if (row.resp && is_in && send_cyc != 3) begin
      report_mismatch(row.name, "data request cycle", 3, send_cyc);
    end
    if (!row.resp && (send_cyc != 0 || hsk_cyc != 0)) begin
      report_failure($sformatf("%s got a response to an ignored or rejected token",
                               row.name));
    end
    if (exp_q.size() != 0) begin
      report_failure($sformatf("%s is missing %0d expected bytes", row.name, exp_q.size()));
    end

    @(posedge clock);
    blk_in_i <= '0;
    usb_rx_i <= '0;
    if (row_fails == 0) begin
      rows_passed++;
      $display("Test %0d %s passed", r, row.name);
    end else begin
      $display("Test %0d %s failed with %0d errors", r, row.name, row_fails);
    end
  endtask

  initial begin
    reset            <= 1'b1;
    usb_addr_i       <= DEV_ADDR;
    tok_i            <= '0;
    hsk_rx_i         <= '0;
    usb_rx_i         <= '0;
    hsk_sent_i       <= 1'b0;
    usb_sent_i       <= 1'b0;
    usb_tx_tready_i  <= 1'b1;
    blk_in_i         <= '0;
    blk_in_ready_i   <= '0;
    blk_out_ready_i  <= '0;
    blk_out_tready_i <= '0;
    load_table();
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    check_reset_state();
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("Tests %0d, passed %0d, failed %0d, errors %0d", NUM_ROWS, rows_passed,
             NUM_ROWS - rows_passed, fail_count);
    if (fail_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run with Verilator, then decide on the simulation log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f vlog.f --top-module usb_transactor_tb \
  -Mdir obj_dir -o usb_sim > build.log 2>&1 \
  && ./obj_dir/usb_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
! grep -q "RESULT: FAIL" sim.log && grep -q "RESULT: PASS" sim.log

//--- vlog.f
+incdir+dv
design/usb_xact_pkg.sv
design/usb_token_dispatch.sv
design/usb_bulk_endpoint.sv
design/usb_response_arbiter.sv
design/usb_transactor.sv
dv/usb_transactor_tb.sv
